//--- design/cfg_pkg.sv
`default_nettype none

package cfg_pkg;

    import frame_pkg::*;

    typedef logic [3:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // byte offsets
    localparam axil_addr_t REG_DEV        = 4'h0; // info, rate, type
    localparam axil_addr_t REG_GROUP_MASK = 4'h4;
    localparam axil_addr_t REG_LONG_MASK  = 4'h8;

    localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

    typedef struct packed {
        byte_t      dev_info;
        byte_t      dev_smpr;
        byte_t      dev_type;
        logic [7:0] group_mask; // bit n enables group n
        logic [7:0] long_mask;  // bit n gives group n two words
    } dev_cfg_t;

endpackage

`default_nettype wire

//--- design/cfg_regs.sv
`timescale 1ns/1ns
`default_nettype none

module cfg_regs import cfg_pkg::*; (
    input  wire               clk,
    input  wire               rst,

    input  wire axil_addr_t   s_axil_awaddr,
    input  wire               s_axil_awvalid,
    output logic              s_axil_awready,
    input  wire axil_data_t   s_axil_wdata,
    input  wire [3:0]         s_axil_wstrb,
    input  wire               s_axil_wvalid,
    output logic              s_axil_wready,
    output logic [1:0]        s_axil_bresp,
    output logic              s_axil_bvalid,
    input  wire               s_axil_bready,

    input  wire axil_addr_t   s_axil_araddr,
    input  wire               s_axil_arvalid,
    output logic              s_axil_arready,
    output axil_data_t        s_axil_rdata,
    output logic [1:0]        s_axil_rresp,
    output logic              s_axil_rvalid,
    input  wire               s_axil_rready,

    output dev_cfg_t          dev_cfg
);

    dev_cfg_t   cfg_q;
    axil_data_t rd_word;
    logic       wr_fire;
    logic       rd_fire;

    // address and data taken in the same cycle
    assign wr_fire        = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
    assign s_axil_awready = wr_fire;
    assign s_axil_wready  = wr_fire;
    assign s_axil_bresp   = AXIL_RESP_OKAY;

    assign s_axil_arready = !s_axil_rvalid;
    assign rd_fire        = s_axil_arvalid && s_axil_arready;
    assign s_axil_rresp   = AXIL_RESP_OKAY;

    assign dev_cfg = cfg_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_q <= '0;
        end else if (wr_fire) begin
            case (s_axil_awaddr)
                REG_DEV: begin
                    if (s_axil_wstrb[0]) cfg_q.dev_info <= s_axil_wdata[7:0];
                    if (s_axil_wstrb[1]) cfg_q.dev_smpr <= s_axil_wdata[15:8];
                    if (s_axil_wstrb[2]) cfg_q.dev_type <= s_axil_wdata[23:16];
                end
                REG_GROUP_MASK: if (s_axil_wstrb[0]) cfg_q.group_mask <= s_axil_wdata[7:0];
                REG_LONG_MASK:  if (s_axil_wstrb[0]) cfg_q.long_mask <= s_axil_wdata[7:0];
                default: ; // unmapped, dropped
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_axil_bvalid <= 1'b0;
            s_axil_rvalid <= 1'b0;
        end else begin
            if (wr_fire)
                s_axil_bvalid <= 1'b1;
            else if (s_axil_bready)
                s_axil_bvalid <= 1'b0;

            if (rd_fire)
                s_axil_rvalid <= 1'b1;
            else if (s_axil_rready)
                s_axil_rvalid <= 1'b0;
        end
    end

    always_comb begin
        case (s_axil_araddr)
            REG_DEV:        rd_word = {8'h00, cfg_q.dev_type, cfg_q.dev_smpr, cfg_q.dev_info};
            REG_GROUP_MASK: rd_word = {24'h0, cfg_q.group_mask};
            REG_LONG_MASK:  rd_word = {24'h0, cfg_q.long_mask};
            default:        rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_fire) s_axil_rdata <= rd_word;
    end

endmodule

`default_nettype wire

//--- design/frame_pkg.sv
`default_nettype none

package frame_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [63:0] sample_word_t;
    typedef logic [2:0]  group_idx_t;

    // what the sequencer hands to the serializer
    typedef enum logic [1:0] {
        ITEM_HDR,
        ITEM_DATA,
        ITEM_END
    } item_kind_t;

    // hdr payload: info [7:0], rate [15:8], type [23:16]
    typedef struct packed {
        item_kind_t   kind;
        sample_word_t payload;
    } frame_item_t;

    localparam byte_t SYNC0 = 8'h55;
    localparam byte_t SYNC1 = 8'hAA;

endpackage

`default_nettype wire

//--- design/frame_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module frame_serializer import frame_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire frame_item_t  item,
    input  wire               item_valid,
    output logic              item_ready,
    output byte_t             tx_data,
    output logic              tx_valid,
    input  wire               tx_ready,
    output logic              tx_last,
    output logic              frame_sent
);

    frame_item_t cur;
    logic        cur_valid;
    logic [2:0]  cnt;        // byte within current item
    logic [2:0]  data_idx;
    byte_t       csum;
    logic        last_byte;
    logic        tx_fire;
    logic        item_fire;

    assign tx_valid   = cur_valid;
    assign tx_fire    = tx_valid && tx_ready;
    assign tx_last    = cur_valid && (cur.kind == ITEM_END);
    assign frame_sent = tx_fire && tx_last;

    // next item only once the last byte of this one goes out
    assign item_ready = !cur_valid || (tx_fire && last_byte);
    assign item_fire  = item_valid && item_ready;

    assign data_idx = 3'd7 - cnt; // msb first

    always_comb begin
        case (cur.kind)
            ITEM_HDR:  last_byte = (cnt == 3'd4);
            ITEM_DATA: last_byte = (cnt == 3'd7);
            default:   last_byte = 1'b1;
        endcase
    end

    always_comb begin
        case (cur.kind)
            ITEM_HDR: begin
                case (cnt)
                    3'd0:    tx_data = SYNC0;
                    3'd1:    tx_data = SYNC1;
                    3'd2:    tx_data = cur.payload[7:0];   // info
                    3'd3:    tx_data = cur.payload[15:8];  // rate
                    default: tx_data = cur.payload[23:16]; // type
                endcase
            end
            ITEM_DATA: tx_data = cur.payload[{data_idx, 3'b000} +: 8];
            default:   tx_data = csum;
        endcase
    end

    always_ff @(posedge clk) begin
        if (item_fire) cur <= item;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_valid <= 1'b0;
            cnt       <= '0;
            csum      <= '0;
        end else begin
            if (item_fire) begin
                cur_valid <= 1'b1;
                cnt       <= '0;
            end else if (tx_fire && last_byte) begin
                cur_valid <= 1'b0;
            end else if (tx_fire) begin
                cnt <= cnt + 1'b1;
            end

            if (tx_fire) begin
                if (cur.kind == ITEM_END)
                    csum <= '0; // ready for next frame
                else if (cur.kind == ITEM_DATA)
                    csum <= csum + tx_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/frame_top.sv
`timescale 1ns/1ns
`default_nettype none

module frame_top import frame_pkg::*, cfg_pkg::*; #(
    parameter int NUM_GROUPS = 8
) (
    input  wire               clk,
    input  wire               rst,

    input  wire axil_addr_t   s_axil_awaddr,
    input  wire               s_axil_awvalid,
    output logic              s_axil_awready,
    input  wire axil_data_t   s_axil_wdata,
    input  wire [3:0]         s_axil_wstrb,
    input  wire               s_axil_wvalid,
    output logic              s_axil_wready,
    output logic [1:0]        s_axil_bresp,
    output logic              s_axil_bvalid,
    input  wire               s_axil_bready,
    input  wire axil_addr_t   s_axil_araddr,
    input  wire               s_axil_arvalid,
    output logic              s_axil_arready,
    output axil_data_t        s_axil_rdata,
    output logic [1:0]        s_axil_rresp,
    output logic              s_axil_rvalid,
    input  wire               s_axil_rready,

    input  wire               frame_start,
    output logic              frame_done,

    output logic [7:0]        group_req,
    input  wire               group_valid,
    input  wire sample_word_t group_data,

    output byte_t             tx_data,
    output logic              tx_valid,
    input  wire               tx_ready,
    output logic              tx_last
);

    dev_cfg_t    dev_cfg;
    frame_item_t item;
    logic        item_valid;
    logic        item_ready;
    logic        frame_sent;

    cfg_regs cfg_regs_i (
        .clk            (clk),
        .rst            (rst),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .dev_cfg        (dev_cfg)
    );

    group_sequencer #(
        .NUM_GROUPS (NUM_GROUPS)
    ) group_sequencer_i (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .frame_done  (frame_done),
        .dev_cfg     (dev_cfg),
        .group_req   (group_req),
        .group_valid (group_valid),
        .group_data  (group_data),
        .item        (item),
        .item_valid  (item_valid),
        .item_ready  (item_ready),
        .frame_sent  (frame_sent)
    );

    frame_serializer frame_serializer_i (
        .clk        (clk),
        .rst        (rst),
        .item       (item),
        .item_valid (item_valid),
        .item_ready (item_ready),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .tx_last    (tx_last),
        .frame_sent (frame_sent)
    );

endmodule

`default_nettype wire

//--- design/group_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module group_sequencer import frame_pkg::*, cfg_pkg::*; #(
    parameter int NUM_GROUPS = 8
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               frame_start,
    output logic              frame_done,
    input  wire dev_cfg_t     dev_cfg,
    output logic [7:0]        group_req,
    input  wire               group_valid,
    input  wire sample_word_t group_data,
    output frame_item_t       item,
    output logic              item_valid,
    input  wire               item_ready,
    input  wire               frame_sent
);

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_HDR,
        SEQ_SCAN,
        SEQ_WAIT,
        SEQ_END,
        SEQ_DRAIN,
        SEQ_DONE
    } seq_state_t;

    seq_state_t  state;
    dev_cfg_t    cfg_q;      // config for this frame
    group_idx_t  grp;
    logic        second_word;

    frame_item_t ibuf [2];
    logic        wr_ptr;
    logic        rd_ptr;
    logic [1:0]  count;
    logic        buf_full;
    logic        push;
    logic        pop;
    frame_item_t push_item;

    assign buf_full   = (count == 2'd2);
    assign item_valid = (count != 2'd0);
    assign item       = ibuf[rd_ptr];
    assign pop        = item_valid && item_ready;
    assign frame_done = (state == SEQ_DONE);

    always_comb begin
        push              = 1'b0;
        push_item.kind    = ITEM_END;
        push_item.payload = '0;
        case (state)
            SEQ_HDR: begin
                push              = !buf_full;
                push_item.kind    = ITEM_HDR;
                push_item.payload = {40'h0, cfg_q.dev_type, cfg_q.dev_smpr, cfg_q.dev_info};
            end
            SEQ_WAIT: begin
                push              = group_valid; // space was checked at request time
                push_item.kind    = ITEM_DATA;
                push_item.payload = group_data;
            end
            SEQ_END: push = !buf_full;
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= SEQ_IDLE;
            cfg_q       <= '0;
            grp         <= '0;
            second_word <= 1'b0;
            group_req   <= '0;
        end else begin
            group_req <= '0;
            case (state)
                SEQ_IDLE: if (frame_start) begin
                    cfg_q       <= dev_cfg;
                    grp         <= group_idx_t'(NUM_GROUPS - 1);
                    second_word <= 1'b0;
                    state       <= SEQ_HDR;
                end
                SEQ_HDR: if (!buf_full) state <= SEQ_SCAN;
                SEQ_SCAN: begin
                    if (!cfg_q.group_mask[grp]) begin
                        if (grp == '0) state <= SEQ_END;
                        else grp <= grp - 1'b1;
                    end else if (!buf_full) begin
                        group_req <= 8'h01 << grp;
                        state     <= SEQ_WAIT;
                    end
                end
                SEQ_WAIT: if (group_valid) begin
                    if (cfg_q.long_mask[grp] && !second_word) begin
                        second_word <= 1'b1; // same group again
                        state       <= SEQ_SCAN;
                    end else begin
                        second_word <= 1'b0;
                        if (grp == '0) state <= SEQ_END;
                        else begin
                            grp   <= grp - 1'b1;
                            state <= SEQ_SCAN;
                        end
                    end
                end
                SEQ_END:   if (!buf_full) state <= SEQ_DRAIN;
                SEQ_DRAIN: if (frame_sent) state <= SEQ_DONE;
                SEQ_DONE:  if (!frame_start) state <= SEQ_IDLE;
                default:   state <= SEQ_IDLE;
            endcase
        end
    end

    // 2-entry item buffer
    always_ff @(posedge clk) begin
        if (push) ibuf[wr_ptr] <= push_item;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop)  rd_ptr <= ~rd_ptr;
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_frame_top -o tb_frame_top
./obj_dir/tb_frame_top | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- src.f
+incdir+test
design/frame_pkg.sv
design/cfg_pkg.sv
design/cfg_regs.sv
design/group_sequencer.sv
design/frame_serializer.sv
design/frame_top.sv
test/tb_frame_top.sv

//--- test/tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

localparam int AXIL_TIMEOUT = 50; // cycles per handshake

// 64-bit xorshift, state lives in the testbench
function automatic logic [63:0] xorshift64();
    logic [63:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    rng_state = x;
    return x;
endfunction

task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                          input logic [3:0] strb);
    int n;
    @(posedge clk);
    s_axil_awaddr  <= addr;
    s_axil_awvalid <= 1'b1;
    s_axil_wdata   <= data;
    s_axil_wstrb   <= strb;
    s_axil_wvalid  <= 1'b1;
    s_axil_bready  <= 1'b1;
    n = 0;
    @(posedge clk);
    while (!(s_axil_awready && s_axil_wready)) begin
        assert (n < AXIL_TIMEOUT) else report_failure("write address and data never accepted");
        n++;
        @(posedge clk);
    end
    s_axil_awvalid <= 1'b0;
    s_axil_wvalid  <= 1'b0;
    n = 0;
    @(posedge clk);
    while (!s_axil_bvalid) begin
        assert (n < AXIL_TIMEOUT) else report_failure("write response never arrived");
        n++;
        @(posedge clk);
    end
    assert (s_axil_bresp == 2'b00) else report_mismatch("bresp", 64'(0), 64'(s_axil_bresp));
    s_axil_bready <= 1'b0;
endtask

task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
    int n;
    @(posedge clk);
    s_axil_araddr  <= addr;
    s_axil_arvalid <= 1'b1;
    s_axil_rready  <= 1'b1;
    n = 0;
    @(posedge clk);
    while (!s_axil_arready) begin
        assert (n < AXIL_TIMEOUT) else report_failure("read address never accepted");
        n++;
        @(posedge clk);
    end
    s_axil_arvalid <= 1'b0;
    n = 0;
    @(posedge clk);
    while (!s_axil_rvalid) begin
        assert (n < AXIL_TIMEOUT) else report_failure("read data never arrived");
        n++;
        @(posedge clk);
    end
    assert (s_axil_rresp == 2'b00) else report_mismatch("rresp", 64'(0), 64'(s_axil_rresp));
    data = s_axil_rdata;
    s_axil_rready <= 1'b0;
endtask

`endif

//--- test/tb_frame_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_frame_top import frame_pkg::*, cfg_pkg::*;;

    localparam int FRAME_TIMEOUT = 3000;
    localparam int DONE_TIMEOUT  = 5;

    logic         clk = 1'b0;
    logic         rst;
    axil_addr_t   s_axil_awaddr;
    logic         s_axil_awvalid;
    logic         s_axil_awready;
    axil_data_t   s_axil_wdata;
    logic [3:0]   s_axil_wstrb;
    logic         s_axil_wvalid;
    logic         s_axil_wready;
    logic [1:0]   s_axil_bresp;
    logic         s_axil_bvalid;
    logic         s_axil_bready;
    axil_addr_t   s_axil_araddr;
    logic         s_axil_arvalid;
    logic         s_axil_arready;
    axil_data_t   s_axil_rdata;
    logic [1:0]   s_axil_rresp;
    logic         s_axil_rvalid;
    logic         s_axil_rready;
    logic         frame_start;
    logic         frame_done;
    logic [7:0]   group_req;
    logic         group_valid = 1'b0;
    sample_word_t group_data = '0;
    byte_t        tx_data;
    logic         tx_valid;
    logic         tx_ready = 1'b1;
    logic         tx_last;

    logic [63:0]  rng_state = 64'd73;
    string        test_name = "reset";
    logic         rand_ready;
    byte_t        cfg_info, cfg_rate, cfg_type, cfg_gmask, cfg_lmask;

    logic [7:0]   exp_bytes [$];
    int           exp_groups [$];
    logic [63:0]  exp_words [$];
    logic         frame_tx_done = 1'b0; // tx_last seen this frame

    logic         fetch_busy = 1'b0;
    logic [2:0]   resp_wait;
    logic [63:0]  resp_word;
    logic         stall_q = 1'b0;
    byte_t        stall_data;
    logic         stall_last;

    `include "tb_axil_tasks.svh"

    frame_top #(
        .NUM_GROUPS (8)
    ) dut_i (
        .clk            (clk),
        .rst            (rst),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .frame_start    (frame_start),
        .frame_done     (frame_done),
        .group_req      (group_req),
        .group_valid    (group_valid),
        .group_data     (group_data),
        .tx_data        (tx_data),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready),
        .tx_last        (tx_last)
    );

    always #10 clk = ~clk;

    task automatic finish_failed();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("test %s: %s", test_name, msg);
        finish_failed();
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("ERR %s %s expected %0h actual %0h", test_name, what, expected, actual);
        finish_failed();
    endtask

    task automatic check_read(input axil_addr_t addr, input axil_data_t expected);
        axil_data_t got;
        axil_read(addr, got);
        assert (got == expected) else report_mismatch("rdata", 64'(expected), 64'(got));
    endtask

    task automatic write_config(input byte_t info, input byte_t rate, input byte_t dtype,
                                input byte_t gmask, input byte_t lmask);
        axil_write(REG_DEV, {8'h00, dtype, rate, info}, 4'hF);
        axil_write(REG_GROUP_MASK, {24'h0, gmask}, 4'h1);
        axil_write(REG_LONG_MASK, {24'h0, lmask}, 4'h1);
        cfg_info  = info;
        cfg_rate  = rate;
        cfg_type  = dtype;
        cfg_gmask = gmask;
        cfg_lmask = lmask;
    endtask

    // expected frame from the config, then one full start/done handshake
    task automatic run_frame();
        logic [63:0] word;
        byte_t       sum;
        int          g;
        int          r;
        int          b;
        int          n;
        exp_bytes.delete();
        exp_groups.delete();
        exp_words.delete();
        exp_bytes.push_back(8'h55);
        exp_bytes.push_back(8'hAA);
        exp_bytes.push_back(cfg_info);
        exp_bytes.push_back(cfg_rate);
        exp_bytes.push_back(cfg_type);
        sum = 8'h00;
        for (g = 7; g >= 0; g--) begin
            if (cfg_gmask[g]) begin
                for (r = 0; r < (cfg_lmask[g] ? 2 : 1); r++) begin
                    word = xorshift64();
                    exp_groups.push_back(g);
                    exp_words.push_back(word);
                    for (b = 7; b >= 0; b--) begin
                        exp_bytes.push_back(word[b*8 +: 8]);
                        sum = sum + word[b*8 +: 8];
                    end
                end
            end
        end
        exp_bytes.push_back(sum);
        frame_tx_done = 1'b0;

        @(posedge clk);
        frame_start <= 1'b1;
        n = 0;
        @(posedge clk);
        while (!frame_done) begin
            assert (n < FRAME_TIMEOUT) else report_failure("frame_done never rose");
            n++;
            @(posedge clk);
        end
        assert (exp_bytes.size() == 0) else report_failure("frame ended with bytes missing");
        assert (exp_groups.size() == 0) else report_failure("frame ended with groups unfetched");

        repeat (4) begin
            @(posedge clk);
            assert (frame_done) else report_failure("frame_done fell while frame_start held");
        end
        frame_start <= 1'b0;
        n = 0;
        @(posedge clk);
        while (frame_done) begin
            assert (n < DONE_TIMEOUT) else report_failure("frame_done stuck after frame_start fell");
            n++;
            @(posedge clk);
        end
    endtask

    // group model, one fetch at a time
    always @(posedge clk) begin : group_model
        logic [63:0] rnd;
        logic [7:0]  exp_req;
        if (rst) begin
            group_valid <= 1'b0;
            fetch_busy = 1'b0;
        end else begin
            group_valid <= 1'b0;
            if (fetch_busy) begin
                if (resp_wait == 3'd1) begin
                    group_valid <= 1'b1;
                    group_data  <= resp_word;
                    fetch_busy = 1'b0;
                end else begin
                    resp_wait = resp_wait - 3'd1;
                end
            end
            if (group_req != 8'h00) begin
                assert ($onehot(group_req)) else report_failure("group_req is not one-hot");
                assert (!fetch_busy) else report_failure("second fetch while one outstanding");
                assert (exp_groups.size() != 0) else report_failure("unexpected group request");
                exp_req = 8'h01 << exp_groups.pop_front();
                assert (group_req == exp_req)
                    else report_mismatch("group_req", 64'(exp_req), 64'(group_req));
                resp_word = exp_words.pop_front();
                rnd = xorshift64();
                resp_wait = {1'b0, rnd[1:0]} + 3'd1; // 1 to 4 cycles
                fetch_busy = 1'b1;
            end
        end
    end

    always @(posedge clk) begin : ready_driver
        logic [63:0] rnd;
        if (rand_ready) begin
            rnd = xorshift64();
            tx_ready <= (rnd[1:0] != 2'b00);
        end else begin
            tx_ready <= 1'b1;
        end
    end

    // byte monitor
    always @(posedge clk) begin
        if (!rst) begin
            assert (!frame_done || frame_tx_done)
                else report_failure("frame_done high before the last byte");
            if (stall_q) begin
                assert (tx_valid) else report_failure("tx_valid dropped during a stall");
                assert (tx_data == stall_data)
                    else report_mismatch("stalled tx_data", 64'(stall_data), 64'(tx_data));
                assert (tx_last == stall_last)
                    else report_mismatch("stalled tx_last", 64'(stall_last), 64'(tx_last));
            end
            if (tx_valid && tx_ready) begin
                assert (exp_bytes.size() != 0) else report_failure("byte sent with none expected");
                assert (tx_data == exp_bytes[0])
                    else report_mismatch("tx_data", 64'(exp_bytes[0]), 64'(tx_data));
                assert (tx_last == (exp_bytes.size() == 1))
                    else report_mismatch("tx_last", 64'(exp_bytes.size() == 1), 64'(tx_last));
                if (tx_last)
                    frame_tx_done = 1'b1;
                void'(exp_bytes.pop_front());
            end
            stall_q    = tx_valid && !tx_ready;
            stall_data = tx_data;
            stall_last = tx_last;
        end
    end

    initial begin
        rst            <= 1'b1;
        s_axil_awaddr  <= '0;
        s_axil_awvalid <= 1'b0;
        s_axil_wdata   <= '0;
        s_axil_wstrb   <= '0;
        s_axil_wvalid  <= 1'b0;
        s_axil_bready  <= 1'b0;
        s_axil_araddr  <= '0;
        s_axil_arvalid <= 1'b0;
        s_axil_rready  <= 1'b0;
        frame_start    <= 1'b0;
        rand_ready     <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (!tx_valid && !frame_done && group_req == 8'h00 && !s_axil_bvalid
                && !s_axil_rvalid) else report_failure("outputs not idle after reset");

        test_name = "regs";
        axil_write(REG_DEV, 32'h00C3B2A1, 4'hF);
        check_read(REG_DEV, 32'h00C3B2A1);
        axil_write(REG_GROUP_MASK, 32'h000000A5, 4'hF);
        check_read(REG_GROUP_MASK, 32'h000000A5);
        axil_write(REG_LONG_MASK, 32'h0000003C, 4'hF);
        check_read(REG_LONG_MASK, 32'h0000003C);
        axil_write(REG_DEV, 32'h00FF77EE, 4'b0010); // rate byte only
        check_read(REG_DEV, 32'h00C377A1);
        check_read(4'hC, 32'h00000000);

        test_name = "full_frame";
        write_config(8'h3C, 8'h14, 8'h7E, 8'hFF, 8'h00);
        run_frame();

        test_name = "mask_long";
        write_config(8'h01, 8'h20, 8'h42, 8'hB6, 8'h93); // group 0 long but disabled
        run_frame();

        test_name = "empty_frame";
        write_config(8'h9A, 8'h08, 8'h11, 8'h00, 8'hFF);
        run_frame();

        test_name = "backpressure";
        rand_ready <= 1'b1;
        write_config(8'h5D, 8'h30, 8'h66, 8'hFF, 8'h55);
        run_frame();

        test_name = "second_frame";
        write_config(8'hE0, 8'h0C, 8'h21, 8'h0F, 8'h0A);
        run_frame();
        run_frame();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
